// File: hdl/or1k_dbg_pkg.sv
/*
 * OR1K debug module shared definitions
 * Data register field positions, bus widths, CRC constants,
 * opcode, FSM state and TDO select encodings
 */
`default_nettype none

package or1k_dbg_pkg;

  localparam int NB_CORES    = 4;
  localparam int CPU_ADDR_W  = 16;                 // SPR address width
  localparam int CPU_DATA_W  = 32;
  localparam int DATAREG_LEN = 64;                 // TAP data register length
  localparam int OP_W        = 4;
  localparam int OP_RD_BIT   = 2;                  // Opcode bit set on reads
  localparam int BIT_CNT_W   = 6;

  //////////////////////////////////////////////////////////////////////
  // Data register fields, MSB positions
  localparam int TOP_FLAG_POS = 63;                // 0 means command is for us
  localparam int OP_MSB       = 62;
  localparam int SEL_MSB      = 58;                // Core or register select
  localparam int ADDR_MSB     = 54;
  localparam int CNT_MSB      = 22;
  localparam int STAT_MSB     = 54;                // Status write data

  localparam int REGSEL_LEN    = 4;
  localparam int INTREG_STATUS = 0;

  typedef logic [CPU_DATA_W-1:0] word_t;
  typedef logic [31:0]           addr_t;
  typedef logic [CPU_ADDR_W-1:0] spr_addr_t;
  typedef logic [15:0]           count_t;
  typedef logic [NB_CORES-1:0]   core_vec_t;
  typedef logic [3:0]            core_sel_t;

  localparam word_t CRC_INIT = '1;
  localparam word_t CRC_POLY = 32'hedb88320;      // Reflected CRC-32

  typedef enum logic [OP_W-1:0] {
    BWRITE32 = 4'd3,
    BREAD32  = 4'd7,
    IREG_WR  = 4'd9,
    IREG_SEL = 4'd13
  } dbg_op_e;

  typedef enum logic [3:0] {
    IDLE, R_BEGIN, R_READY, R_STATUS, R_BURST, R_CRC,
    W_READY, W_WAIT, W_BURST, W_CRC, W_MATCH
  } dbg_state_e;

  typedef enum logic [1:0] {BIU_READY, DATA_OUT, CRC_MATCH, CRC_OUT} tdo_sel_e;

endpackage

`default_nettype wire

// File: hdl/or1k_dbg_ifs.sv
/*
 * Internal debug module interfaces
 * dbg_ctrl_if carries FSM strobes to the datapath and flags back,
 * spr_biu_if carries one request at a time to the bus interface unit
 */
`default_nettype none

interface dbg_ctrl_if import or1k_dbg_pkg::*; ();
  logic     addr_sel;         // 0 loads start address, 1 increments
  logic     addr_ct_en;
  logic     op_reg_en;
  logic     bit_ct_en;
  logic     bit_ct_rst;
  logic     word_ct_sel;      // 0 loads count, 1 decrements
  logic     word_ct_en;
  logic     out_reg_ld_en;
  logic     out_reg_shift_en;
  logic     out_reg_data_sel; // 1 selects internal register data
  tdo_sel_e tdo_sel;
  logic     crc_clr;
  logic     crc_en;
  logic     crc_in_sel;       // 1 takes TDI
  logic     crc_shift_en;
  logic     regsel_ld_en;
  logic     cpusel_ld_en;
  // Flags back to the FSM
  logic     word_count_zero;
  logic     next_count_zero;
  logic     bit_count_max;
  logic     bit_count_32;
  logic     rd_op;            // Latched opcode is a read

  modport ctrl (
    output addr_sel, addr_ct_en, op_reg_en, bit_ct_en, bit_ct_rst, word_ct_sel, word_ct_en,
           out_reg_ld_en, out_reg_shift_en, out_reg_data_sel, tdo_sel,
           crc_clr, crc_en, crc_in_sel, crc_shift_en, regsel_ld_en, cpusel_ld_en,
    input  word_count_zero, next_count_zero, bit_count_max, bit_count_32, rd_op
  );
  modport dp (
    input  addr_sel, addr_ct_en, op_reg_en, bit_ct_en, bit_ct_rst, word_ct_sel, word_ct_en,
           out_reg_ld_en, out_reg_shift_en, out_reg_data_sel, tdo_sel,
           crc_clr, crc_en, crc_in_sel, crc_shift_en, regsel_ld_en, cpusel_ld_en,
    output word_count_zero, next_count_zero, bit_count_max, bit_count_32, rd_op
  );
endinterface

interface spr_biu_if import or1k_dbg_pkg::*; ();
  logic  strobe;   // One cycle, latches the request
  logic  rd_wrn;
  addr_t addr;
  word_t wdata;
  word_t rdata;
  logic  rdy;

  modport ctrl (output strobe, rd_wrn, input rdy);
  modport dp   (output addr, wdata, input rdata, rdy);
  modport biu  (input strobe, rd_wrn, addr, wdata, output rdata, rdy);
endinterface

`default_nettype wire

// File: hdl/or1k_dbg_crc32.sv
/*
 * Serial CRC-32, one bit per enabled cycle
 * Doubles as its own LSB-first output shift register
 */
`default_nettype none

module or1k_dbg_crc32
  import or1k_dbg_pkg::*;
(
  input  logic  tck_i,
  input  logic  tlr_i,
  input  logic  clr_i,
  input  logic  en_i,
  input  logic  shift_i,
  input  logic  data_i,
  output word_t crc_o,
  output logic  serial_o
);

  word_t crc_q;
  logic  fb;      // Feedback bit

  assign fb = crc_q[0] ^ data_i;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      crc_q <= CRC_INIT;
    else if (clr_i)
      crc_q <= CRC_INIT;
    else if (en_i)
      crc_q <= (crc_q >> 1) ^ (fb ? CRC_POLY : '0);   // Reflected update
    else if (shift_i)
      crc_q <= crc_q >> 1;
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

`default_nettype wire

// File: hdl/or1k_dbg_datapath.sv
/*
 * Debug module datapath
 * Address, word and bit counters, command latches, output shift
 * register, CRC and TDO select
 */
`default_nettype none

module or1k_dbg_datapath
  import or1k_dbg_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   tdi_i,
  input  logic [DATAREG_LEN-1:0] data_register_i,
  input  core_vec_t              stall_status_i,
  output logic                   module_tdo_o,
  output core_sel_t              cpu_sel_o,
  dbg_ctrl_if.dp                 dbg_if,
  spr_biu_if.dp                  biu_if
);

  addr_t                 addr_cnt;
  count_t                word_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [OP_W-1:0]       op_q;
  logic [REGSEL_LEN-1:0] regsel_q;
  word_t                 out_sreg;     // Shifts LSB first onto TDO
  word_t                 intreg_data;
  word_t                 crc_value;
  logic                  crc_data;
  logic                  crc_serial;
  logic                  crc_match;

  //////////////////////////////////////////////////////////////////////
  // Counters and command latches
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      addr_cnt  <= '0;
      word_cnt  <= '0;
      bit_cnt   <= '0;
      op_q      <= '0;
      regsel_q  <= '0;
      cpu_sel_o <= '0;
    end
    else
    begin
      if (dbg_if.addr_ct_en)
        addr_cnt <= dbg_if.addr_sel ? addr_cnt + addr_t'(1)
                                    : data_register_i[ADDR_MSB -: $bits(addr_t)];
      if (dbg_if.word_ct_en)
        word_cnt <= dbg_if.word_ct_sel ? word_cnt - count_t'(1)
                                       : data_register_i[CNT_MSB -: $bits(count_t)];
      if (dbg_if.bit_ct_rst)
        bit_cnt <= '0;
      else if (dbg_if.bit_ct_en)
        bit_cnt <= bit_cnt + 1'b1;
      if (dbg_if.op_reg_en)    op_q      <= data_register_i[OP_MSB -: OP_W];
      if (dbg_if.regsel_ld_en) regsel_q  <= data_register_i[SEL_MSB -: REGSEL_LEN];
      if (dbg_if.cpusel_ld_en) cpu_sel_o <= data_register_i[SEL_MSB -: $bits(core_sel_t)];
    end
  end

  assign dbg_if.word_count_zero = (word_cnt == '0);
  assign dbg_if.next_count_zero = (word_cnt == count_t'(1));   // Last word in flight
  assign dbg_if.bit_count_max   = (bit_cnt == BIT_CNT_W'(CPU_DATA_W - 1));
  assign dbg_if.bit_count_32    = (bit_cnt == BIT_CNT_W'(CPU_DATA_W));
  assign dbg_if.rd_op           = op_q[OP_RD_BIT];

  // Bus request, write word is TDI over the top 31 register bits
  assign biu_if.addr  = addr_cnt;
  assign biu_if.wdata = {tdi_i, data_register_i[DATAREG_LEN-1 -: CPU_DATA_W-1]};

  //////////////////////////////////////////////////////////////////////
  // Output shift register
  assign intreg_data = (regsel_q == REGSEL_LEN'(INTREG_STATUS)) ? word_t'(stall_status_i) : '0;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      out_sreg <= '0;
    else if (dbg_if.out_reg_ld_en)
      out_sreg <= dbg_if.out_reg_data_sel ? intreg_data : biu_if.rdata;
    else if (dbg_if.out_reg_shift_en)
      out_sreg <= {1'b0, out_sreg[CPU_DATA_W-1:1]};
  end

  // CRC over write data from TDI or read data leaving on TDO
  assign crc_data  = dbg_if.crc_in_sel ? tdi_i : out_sreg[0];
  assign crc_match = (data_register_i[DATAREG_LEN-1 -: CPU_DATA_W] == crc_value);

  or1k_dbg_crc32 i_crc (
    .tck_i, .tlr_i,
    .clr_i    (dbg_if.crc_clr),
    .en_i     (dbg_if.crc_en),
    .shift_i  (dbg_if.crc_shift_en),
    .data_i   (crc_data),
    .crc_o    (crc_value),
    .serial_o (crc_serial)
  );

  always_comb
  begin
    case (dbg_if.tdo_sel)
      BIU_READY: module_tdo_o = biu_if.rdy;
      DATA_OUT:  module_tdo_o = out_sreg[0];
      CRC_MATCH: module_tdo_o = crc_match;
      default:   module_tdo_o = crc_serial;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/or1k_dbg_ctrl.sv
/*
 * Debug module burst FSM and command decoder
 * Decodes the shifted-in command and steers counters, shift
 * registers, CRC and bus strobes per state
 */
`default_nettype none

module or1k_dbg_ctrl
  import or1k_dbg_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic [DATAREG_LEN-1:0] data_register_i,
  output logic                   top_inhibit_o,
  output logic                   status_we_o,
  dbg_ctrl_if.ctrl               dbg_if,
  spr_biu_if.ctrl                biu_if
);

  dbg_state_e state;
  dbg_state_e next_state;
  dbg_op_e    op_in;        // Opcode straight from the data register
  logic       cmd_upd;      // Update of a command for this module
  logic       burst_instr;
  logic       ireg_instr;
  logic       ireg_wr;
  logic       rd_load;      // Load next read word into the output register

  //////////////////////////////////////////////////////////////////////
  // Command decode, only valid before the opcode is latched
  assign op_in       = dbg_op_e'(data_register_i[OP_MSB -: OP_W]);
  assign cmd_upd     = module_select_i & ~data_register_i[TOP_FLAG_POS] & update_dr_i;
  assign burst_instr = (op_in == BWRITE32) | (op_in == BREAD32);
  assign ireg_instr  = (op_in == IREG_WR) | (op_in == IREG_SEL);
  assign ireg_wr     = (op_in == IREG_WR) &&
                       (data_register_i[SEL_MSB -: REGSEL_LEN] == REGSEL_LEN'(INTREG_STATUS));

  assign status_we_o   = (state == IDLE) & cmd_upd & ireg_wr;
  assign top_inhibit_o = !(state inside {IDLE, R_BEGIN, R_READY, W_READY});
  assign biu_if.rd_wrn = dbg_if.rd_op;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      state <= IDLE;
    else
      state <= next_state;
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (cmd_upd && burst_instr)
          next_state = op_in[OP_RD_BIT] ? R_BEGIN : W_READY;
      R_BEGIN:  next_state = dbg_if.word_count_zero ? IDLE : R_READY;  // Zero count ends here
      R_READY:  if (module_select_i && capture_dr_i) next_state = R_STATUS;
      R_STATUS: if (biu_if.rdy) next_state = R_BURST;                  // First word fetched
      R_BURST:  if (dbg_if.bit_count_max && dbg_if.word_count_zero) next_state = R_CRC;
      W_READY:
        if (dbg_if.word_count_zero)
          next_state = IDLE;
        else if (module_select_i && capture_dr_i)
          next_state = W_WAIT;
      W_WAIT:
        if (module_select_i && data_register_i[TOP_FLAG_POS])  // Start bit reached the top
          next_state = W_BURST;
      W_BURST:  if (dbg_if.bit_count_max && dbg_if.word_count_zero) next_state = W_CRC;
      W_CRC:    if (dbg_if.bit_count_32) next_state = W_MATCH;
      R_CRC, W_MATCH: ;                                             // Hold until update
      default:  next_state = IDLE;
    endcase
    if (state != IDLE && update_dr_i)                              // Host ends the burst
      next_state = IDLE;
  end

  assign rd_load = ((state == R_STATUS) && (next_state == R_BURST)) ||
                   ((state == R_BURST) && dbg_if.bit_count_max);

  //////////////////////////////////////////////////////////////////////
  // Per-state controls
  always_comb
  begin
    dbg_if.addr_sel         = 1'b1;
    dbg_if.addr_ct_en       = 1'b0;
    dbg_if.op_reg_en        = 1'b0;
    dbg_if.bit_ct_en        = 1'b0;
    dbg_if.bit_ct_rst       = 1'b0;
    dbg_if.word_ct_sel      = 1'b1;
    dbg_if.word_ct_en       = 1'b0;
    dbg_if.out_reg_ld_en    = 1'b0;
    dbg_if.out_reg_shift_en = 1'b0;
    dbg_if.out_reg_data_sel = 1'b1;
    dbg_if.tdo_sel          = DATA_OUT;
    dbg_if.crc_clr          = 1'b0;
    dbg_if.crc_en           = 1'b0;
    dbg_if.crc_in_sel       = 1'b0;   // Read data from output LSB
    dbg_if.crc_shift_en     = 1'b0;
    dbg_if.regsel_ld_en     = 1'b0;
    dbg_if.cpusel_ld_en     = 1'b0;
    biu_if.strobe           = 1'b0;
    case (state)
      IDLE:
      begin
        dbg_if.addr_sel         = 1'b0;                        // Start address
        dbg_if.word_ct_sel      = 1'b0;                        // Word count
        dbg_if.out_reg_ld_en    = module_select_i & capture_dr_i;  // Status word
        dbg_if.out_reg_shift_en = module_select_i & shift_dr_i;
        dbg_if.regsel_ld_en     = cmd_upd & ireg_instr;
        dbg_if.cpusel_ld_en     = cmd_upd & burst_instr;
        if (next_state != IDLE)
        begin
          dbg_if.addr_ct_en = 1'b1;
          dbg_if.op_reg_en  = 1'b1;
          dbg_if.bit_ct_rst = 1'b1;
          dbg_if.word_ct_en = 1'b1;
          dbg_if.crc_clr    = 1'b1;
        end
      end
      R_BEGIN:
        if (!dbg_if.word_count_zero)
        begin
          biu_if.strobe     = 1'b1;                            // First read access
          dbg_if.addr_ct_en = 1'b1;
        end
      R_STATUS: dbg_if.tdo_sel = BIU_READY;
      R_BURST:
      begin
        dbg_if.out_reg_shift_en = 1'b1;
        dbg_if.bit_ct_en        = 1'b1;
        dbg_if.crc_en           = 1'b1;
      end
      R_CRC:
      begin
        dbg_if.tdo_sel      = CRC_OUT;
        dbg_if.crc_shift_en = 1'b1;
      end
      W_WAIT:
        if (next_state == W_BURST)
        begin
          dbg_if.bit_ct_en  = 1'b1;
          dbg_if.word_ct_en = 1'b1;   // Pre-decrement
          dbg_if.crc_en     = 1'b1;   // TDI already holds bit 0
          dbg_if.crc_in_sel = 1'b1;
        end
      W_BURST:
      begin
        dbg_if.bit_ct_en  = 1'b1;
        dbg_if.crc_en     = 1'b1;
        dbg_if.crc_in_sel = 1'b1;
        if (dbg_if.bit_count_max)
        begin
          dbg_if.bit_ct_rst = 1'b1;
          biu_if.strobe     = 1'b1;   // Write the completed word
          dbg_if.addr_ct_en = 1'b1;
          dbg_if.word_ct_en = 1'b1;
        end
      end
      W_CRC:
      begin
        dbg_if.bit_ct_en = 1'b1;
        if (dbg_if.bit_count_32) dbg_if.tdo_sel = CRC_MATCH;  // Match bit goes out now
      end
      W_MATCH: dbg_if.tdo_sel = CRC_MATCH;
      default: ;
    endcase
    if (rd_load)
    begin
      dbg_if.out_reg_data_sel = 1'b0;                         // BIU data
      dbg_if.out_reg_ld_en    = 1'b1;
      dbg_if.bit_ct_rst       = 1'b1;
      dbg_if.word_ct_en       = 1'b1;
      if (!dbg_if.next_count_zero && !dbg_if.word_count_zero)  // Prefetch next word
      begin
        biu_if.strobe     = 1'b1;
        dbg_if.addr_ct_en = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/or1k_spr_biu.sv
/*
 * Bus interface unit to the cores' SPR buses
 * Latches one request, strobes the selected core until it
 * acknowledges, and holds read data
 */
`default_nettype none

module or1k_spr_biu
  import or1k_dbg_pkg::*;
(
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  core_sel_t                           cpu_sel_i,
  input  logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_i,
  input  core_vec_t                           cpu_ack_i,
  output logic [NB_CORES-1:0][CPU_ADDR_W-1:0] cpu_addr_o,
  output logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_o,
  output core_vec_t                           cpu_stb_o,
  output core_vec_t                           cpu_we_o,
  spr_biu_if.biu                              biu_if
);

  logic      stb_q;      // Access in progress
  core_sel_t sel_q;
  logic      rd_q;
  spr_addr_t addr_q;
  word_t     wdata_q;
  logic      sel_ack;
  word_t     sel_data;

  // Selected core's response, unknown cores complete at once
  always_comb
  begin
    sel_ack  = (sel_q >= core_sel_t'(NB_CORES));
    sel_data = '0;
    for (int i = 0; i < NB_CORES; i++)
    begin
      if (sel_q == core_sel_t'(i))
      begin
        sel_ack  = cpu_ack_i[i];
        sel_data = cpu_data_i[i];
      end
    end
  end

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      stb_q <= 1'b0;
    else if (biu_if.strobe)
      stb_q <= 1'b1;
    else if (stb_q && sel_ack)
      stb_q <= 1'b0;   // Done on ack
  end

  always_ff @(posedge tck_i)
  begin
    if (biu_if.strobe)
    begin
      sel_q   <= cpu_sel_i;
      rd_q    <= biu_if.rd_wrn;
      addr_q  <= biu_if.addr[CPU_ADDR_W-1:0];
      wdata_q <= biu_if.wdata;
    end
    if (stb_q && sel_ack && rd_q)
      biu_if.rdata <= sel_data;
  end

  assign biu_if.rdy = ~stb_q;

  // Steer to the selected core, others see an idle bus
  always_comb
  begin
    for (int i = 0; i < NB_CORES; i++)
    begin
      cpu_addr_o[i] = addr_q;
      cpu_data_o[i] = wdata_q;
      cpu_stb_o[i]  = stb_q && (sel_q == core_sel_t'(i));
      cpu_we_o[i]   = stb_q && !rd_q && (sel_q == core_sel_t'(i));
    end
  end

endmodule

`default_nettype wire

// File: hdl/or1k_dbg_status_reg.sv
/*
 * Per-core stall register
 * Written by debug command, a breakpoint stalls its own core
 */
`default_nettype none

module or1k_dbg_status_reg
  import or1k_dbg_pkg::*;
(
  input  logic      tck_i,
  input  logic      tlr_i,
  input  logic      we_i,
  input  core_vec_t data_i,
  input  core_vec_t bp_i,
  output core_vec_t stall_o
);

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      stall_o <= '0;                               // All cores run
    else
      stall_o <= (we_i ? data_i : stall_o) | bp_i;  // Breakpoint wins
  end

endmodule

`default_nettype wire

// File: hdl/or1k_dbg_top.sv
/*
 * OR1K cluster JTAG debug module
 * Burst SPR reads and writes with CRC-32, core select and
 * per-core stall register, all on the TAP clock
 */
`default_nettype none

module or1k_dbg_top
  import or1k_dbg_pkg::*;
(
  // JTAG and TAP
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  logic                                tdi_i,
  input  logic                                capture_dr_i,
  input  logic                                shift_dr_i,
  input  logic                                update_dr_i,
  input  logic                                module_select_i,
  input  logic [DATAREG_LEN-1:0]              data_register_i,
  output logic                                module_tdo_o,
  output logic                                top_inhibit_o,
  // Per-core SPR bus
  output logic [NB_CORES-1:0][CPU_ADDR_W-1:0] cpu_addr_o,
  output logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_o,
  output logic [NB_CORES-1:0]                 cpu_we_o,
  output logic [NB_CORES-1:0]                 cpu_stb_o,
  output logic [NB_CORES-1:0]                 cpu_stall_o,
  input  logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_i,
  input  logic [NB_CORES-1:0]                 cpu_ack_i,
  input  logic [NB_CORES-1:0]                 cpu_bp_i
);

  dbg_ctrl_if dbg_if ();
  spr_biu_if  biu_if ();

  core_sel_t cpu_sel;    // Latched core select
  logic      status_we;

  or1k_dbg_ctrl i_ctrl (
    .tck_i, .tlr_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .data_register_i, .top_inhibit_o,
    .status_we_o (status_we),
    .dbg_if      (dbg_if),
    .biu_if      (biu_if)
  );

  or1k_dbg_datapath i_datapath (
    .tck_i, .tlr_i, .tdi_i, .data_register_i, .module_tdo_o,
    .stall_status_i (cpu_stall_o),   // Status word readback
    .cpu_sel_o      (cpu_sel),
    .dbg_if         (dbg_if),
    .biu_if         (biu_if)
  );

  or1k_spr_biu i_biu (
    .tck_i, .tlr_i, .cpu_data_i, .cpu_ack_i, .cpu_addr_o, .cpu_data_o, .cpu_stb_o, .cpu_we_o,
    .cpu_sel_i (cpu_sel),
    .biu_if    (biu_if)
  );

  or1k_dbg_status_reg i_status (
    .tck_i, .tlr_i,
    .we_i   (status_we),
    .data_i (data_register_i[STAT_MSB -: NB_CORES]),
    .bp_i   (cpu_bp_i),
    .stall_o(cpu_stall_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_or1k_dbg.sv
/*
 * OR1K debug module testbench
 * Sequences TAP capture, shift and update, models the core SPR buses
 * and checks bursts, CRC and the stall register against references
 */
`default_nettype none

module tb_or1k_dbg
  import or1k_dbg_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT = 4000;   // Tests need about 1100 cycles
  localparam int N_WORDS     = 3;

  logic                                tck_i;
  logic                                tlr_i;
  logic                                tdi_i;
  logic                                capture_dr_i;
  logic                                shift_dr_i;
  logic                                update_dr_i;
  logic                                module_select_i;
  logic [DATAREG_LEN-1:0]              dr_q = '0;   // Host copy of the TAP data register
  logic                                module_tdo_o;
  logic                                top_inhibit_o;
  logic [NB_CORES-1:0][CPU_ADDR_W-1:0] cpu_addr_o;
  logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_o;
  core_vec_t                           cpu_we_o;
  core_vec_t                           cpu_stb_o;
  core_vec_t                           cpu_stall_o;
  logic [NB_CORES-1:0][CPU_DATA_W-1:0] cpu_data_i;
  core_vec_t                           cpu_ack_i;
  core_vec_t                           cpu_bp_i;

  logic [31:0] lfsr_q = 32'h1a321edc;
  int          cycle_cnt = 0;
  int          access_cnt = 0;           // Completed bus accesses, all cores
  word_t       mem_q [int];              // Written words, key is core and address
  core_vec_t   exp_core_q [$];
  spr_addr_t   exp_addr_q [$];
  word_t       exp_data_q [$];
  int          wait_cnt [NB_CORES];
  logic        busy [NB_CORES];

  or1k_dbg_top i_or1k_dbg_top (
    .tck_i, .tlr_i, .tdi_i, .capture_dr_i, .shift_dr_i, .update_dr_i, .module_select_i,
    .data_register_i (dr_q),
    .module_tdo_o, .top_inhibit_o,
    .cpu_addr_o, .cpu_data_o, .cpu_we_o, .cpu_stb_o, .cpu_stall_o,
    .cpu_data_i, .cpu_ack_i, .cpu_bp_i
  );

  initial
  begin
    tck_i = 1'b0;
    forever #5 tck_i = ~tck_i;
  end

  always @(posedge tck_i)
  begin
    if (shift_dr_i)
      dr_q <= {tdi_i, dr_q[DATAREG_LEN-1:1]};   // TDI enters at the top
  end

  //////////////////////////////////////////////////////////////////////
  // Random source, reference models and checks
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);  // Galois step
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic word_t crc32_ref(input word_t crc, input word_t data);
    word_t c;
    c = crc;
    for (int i = 0; i < CPU_DATA_W; i++)
      c = (c >> 1) ^ ((c[0] ^ data[i]) ? CRC_POLY : '0);   // LSB first
    return c;
  endfunction

  // Fill pattern for never written words
  function automatic word_t mem_read(input int core, input spr_addr_t a);
    int key;
    key = core * 65536 + int'(a);
    if (mem_q.exists(key))
      return mem_q[key];
    else
      return {a ^ 16'hc3a5, ~a} ^ (word_t'(core) << 28);
  endfunction

  function automatic logic [DATAREG_LEN-1:0] make_cmd(input dbg_op_e op, input core_sel_t sel,
                                                     input addr_t addr, input count_t cnt);
    logic [DATAREG_LEN-1:0] c;
    c = '0;                              // Top flag 0, command is for this module
    c[OP_MSB -: OP_W]            = op;
    c[SEL_MSB -: 4]              = sel;
    c[ADDR_MSB -: $bits(addr_t)] = addr;
    c[CNT_MSB -: $bits(count_t)] = cnt;
    return c;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_addr(input string name, input spr_addr_t exp, input spr_addr_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic compare_cores(input string name, input core_vec_t exp, input core_vec_t act);
    if (act !== exp)
      abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
  endtask

  always @(posedge tck_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
      abort_run("Timeout, the run did not finish within the cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Core bus models, ack after 0 to 3 cycles, writes checked on ack
  always @(posedge tck_i)
  begin
    for (int i = 0; i < NB_CORES; i++)
    begin
      if (cpu_ack_i[i])
        cpu_ack_i[i] <= 1'b0;
      else if (cpu_stb_o[i])
      begin
        if (!busy[i])
        begin
          busy[i]     = 1'b1;
          wait_cnt[i] = int'(rand_bits(2));
        end
        if (wait_cnt[i] == 0)
        begin
          busy[i] = 1'b0;
          cpu_ack_i[i] <= 1'b1;
          access_cnt++;
          if (cpu_we_o[i])
          begin
            if (exp_data_q.size() == 0)
              abort_run("A bus write happened that no test asked for");
            compare_cores("write core", exp_core_q.pop_front(), cpu_we_o);
            compare_addr("write address", exp_addr_q.pop_front(), cpu_addr_o[i]);
            compare_word("write data", exp_data_q.pop_front(), cpu_data_o[i]);
            mem_q[i * 65536 + int'(cpu_addr_o[i])] = cpu_data_o[i];
          end
          else
            cpu_data_i[i] <= mem_read(i, cpu_addr_o[i]);
        end
        else
          wait_cnt[i]--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TAP sequencing
  task automatic shift_bit(input logic b, output logic tdo);
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
    shift_dr_i   <= 1'b1;
    tdi_i        <= b;
    @(negedge tck_i);
    tdo = module_tdo_o;                  // Bit leaving on the coming shift edge
  endtask

  task automatic pulse_capture();
    @(posedge tck_i);
    capture_dr_i <= 1'b1;
  endtask

  task automatic pulse_update();
    @(posedge tck_i);
    shift_dr_i  <= 1'b0;
    update_dr_i <= 1'b1;
    @(posedge tck_i);
    update_dr_i <= 1'b0;
  endtask

  task automatic send_cmd(input logic [DATAREG_LEN-1:0] cmd);
    logic unused;
    for (int i = 0; i < DATAREG_LEN; i++)
      shift_bit(cmd[i], unused);
    pulse_update();
  endtask

  task automatic read_status(output core_vec_t v);
    logic b;
    send_cmd(make_cmd(IREG_SEL, core_sel_t'(INTREG_STATUS), '0, '0));
    pulse_capture();
    for (int i = 0; i < NB_CORES; i++)
    begin
      shift_bit(1'b0, b);
      v[i] = b;
    end
    @(posedge tck_i);
    shift_dr_i <= 1'b0;
  endtask

  task automatic burst_write(input core_sel_t core, input spr_addr_t addr, input logic flip);
    word_t words [N_WORDS];
    word_t crc;
    logic  b;
    int    flip_pos;
    crc      = CRC_INIT;
    flip_pos = int'(rand_bits(5));
    for (int w = 0; w < N_WORDS; w++)
    begin
      words[w] = rand_bits(32);
      crc      = crc32_ref(crc, words[w]);
      exp_core_q.push_back(core_vec_t'(1) << core);
      exp_addr_q.push_back(addr + spr_addr_t'(w));
      exp_data_q.push_back(words[w]);
    end
    send_cmd(make_cmd(BWRITE32, core, addr_t'(addr), count_t'(N_WORDS)));
    pulse_capture();
    shift_bit(1'b1, b);                  // Start bit
    compare_bit("inhibit in write burst", 1'b1, top_inhibit_o);
    for (int w = 0; w < N_WORDS; w++)
      for (int i = 0; i < CPU_DATA_W; i++)
        shift_bit(words[w][i], b);
    for (int i = 0; i < CPU_DATA_W; i++)
      shift_bit(crc[i] ^ (flip && i == flip_pos), b);
    shift_bit(1'b0, b);
    compare_bit(flip ? "match bit, bad CRC" : "match bit, good CRC", !flip, b);
    pulse_update();
    repeat (8) @(posedge tck_i);
    if (exp_data_q.size() != 0)
      abort_run("Burst write ended with bus writes still missing");
  endtask

  task automatic burst_read(input core_sel_t core, input spr_addr_t addr, input int n);
    word_t crc;
    word_t act;
    word_t exp_word;
    logic  b;
    crc = CRC_INIT;
    send_cmd(make_cmd(BREAD32, core, addr_t'(addr), count_t'(n)));
    pulse_capture();
    b = 1'b0;
    while (!b)
      shift_bit(1'b0, b);               // Zeros until the BIU is ready
    compare_bit("inhibit in read burst", 1'b1, top_inhibit_o);
    for (int w = 0; w < n; w++)
    begin
      for (int i = 0; i < CPU_DATA_W; i++)
      begin
        shift_bit(1'b0, b);
        act[i] = b;
      end
      exp_word = mem_read(int'(core), addr + spr_addr_t'(w));
      compare_word($sformatf("read word %0d", w), exp_word, act);
      crc = crc32_ref(crc, exp_word);
    end
    for (int i = 0; i < CPU_DATA_W; i++)
    begin
      shift_bit(1'b0, b);
      act[i] = b;
    end
    compare_word("read CRC", crc, act);
    pulse_update();
    @(negedge tck_i);
    compare_bit("inhibit after read burst", 1'b0, top_inhibit_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  initial
  begin
    core_vec_t stall_pat;
    core_vec_t stat;
    int        bp_core;
    core_sel_t core;
    spr_addr_t addr;
    int        accesses;
    tlr_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    cpu_data_i      = '0;
    cpu_ack_i       = '0;
    cpu_bp_i        = '0;
    for (int i = 0; i < NB_CORES; i++)
    begin
      busy[i]     = 1'b0;
      wait_cnt[i] = 0;
    end
    repeat (16) @(posedge tck_i);
    tlr_i <= 1'b0;
    @(negedge tck_i);
    compare_cores("reset strobes", '0, cpu_stb_o);
    compare_cores("reset write enables", '0, cpu_we_o);
    compare_cores("reset stalls", '0, cpu_stall_o);
    compare_bit("reset inhibit", 1'b0, top_inhibit_o);

    // Stall register write, breakpoint and readback
    stall_pat = core_vec_t'(rand_bits(NB_CORES));
    bp_core   = int'(rand_bits(2));
    send_cmd(make_cmd(IREG_WR, core_sel_t'(INTREG_STATUS), {stall_pat, 28'h0}, '0));
    @(negedge tck_i);
    compare_cores("stall write", stall_pat, cpu_stall_o);
    @(posedge tck_i);
    cpu_bp_i <= core_vec_t'(1) << bp_core;
    @(posedge tck_i);
    cpu_bp_i <= '0;
    @(negedge tck_i);
    stall_pat[bp_core] = 1'b1;
    compare_cores("breakpoint stall", stall_pat, cpu_stall_o);
    read_status(stat);
    compare_cores("status readback", stall_pat, stat);

    // Bursts on one random core
    core = core_sel_t'(rand_bits(2));
    addr = spr_addr_t'(rand_bits(16));
    burst_write(core, addr, 1'b0);
    burst_write(core, addr + spr_addr_t'(16), 1'b1);
    burst_read(core, addr, N_WORDS + 1);   // Last word comes from the fill pattern

    // Zero count makes no access, the next command still works
    accesses = access_cnt;
    send_cmd(make_cmd(BREAD32, core, addr_t'(addr), '0));
    repeat (6) @(posedge tck_i);
    compare_word("zero count accesses", word_t'(accesses), word_t'(access_cnt));
    read_status(stat);
    compare_cores("status after zero count", stall_pat, stat);

    if (exp_data_q.size() == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      abort_run("Expected bus writes remain at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/or1k_dbg_pkg.sv
hdl/or1k_dbg_ifs.sv
hdl/or1k_dbg_crc32.sv
hdl/or1k_dbg_datapath.sv
hdl/or1k_dbg_ctrl.sv
hdl/or1k_spr_biu.sv
hdl/or1k_dbg_status_reg.sv
hdl/or1k_dbg_top.sv
bench/tb_or1k_dbg.sv

// File: run_sim.sh
#!/bin/sh
# Build the debug module testbench with Verilator and run it.
# Exit status is the simulator's, non-zero on any failed check.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_or1k_dbg \
  -f sim.f \
  -o tb_or1k_dbg_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_or1k_dbg_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0
